// ==== design/event_sched_pkg.sv ====
`default_nettype none

package event_sched_pkg;

    localparam int ADDR_W     = 16;
    localparam int COORD_W    = 8;
    localparam int ROW_STRIDE = 256;

    // Defaults that event_sched_top passes down
    parameter int HALF_WIN    = 2;   // 1 to 3
    parameter int QUEUE_DEPTH = 16;  // Power of two of at least 2*WIN

    ////////////////////////////////////////////////////////////////////////////
    // Pixel address with the row in the upper byte
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
    } pixel_rc_s;

    typedef union packed {
        logic [ADDR_W-1:0] linear;  // Raster index
        pixel_rc_s         rc;
    } pixel_addr_u;

    // Oldest pending window of one lane
    typedef struct packed {
        logic        vld;
        pixel_addr_u addr;
    } lane_head_s;

endpackage

`default_nettype wire

// ==== design/todo_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module todo_lane import event_sched_pkg::*; #(
    parameter int HALF_WIN    = event_sched_pkg::HALF_WIN,
    parameter int QUEUE_DEPTH = event_sched_pkg::QUEUE_DEPTH,
    parameter int LANE        = 0,
    localparam int WIN        = 2 * HALF_WIN + 1,
    localparam int CNT_W      = $clog2(WIN + 1)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [CNT_W-1:0] push_count,
    input  pixel_addr_u      push_base,
    input  logic             pop,
    output lane_head_s       head
);

    localparam int PTR_W  = $clog2(QUEUE_DEPTH);
    localparam int FILL_W = PTR_W + 1;

    pixel_addr_u        mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [FILL_W-1:0]  fill;
    logic [COORD_W-1:0] lane_row;
    logic [COORD_W-1:0] first_col;

    // Row of this lane relative to the event
    assign lane_row = push_base.rc.row - COORD_W'(HALF_WIN) + COORD_W'(LANE);

    // Only the rightmost push_count columns are new
    assign first_col = push_base.rc.col + COORD_W'(HALF_WIN + 1) - COORD_W'(push_count);

    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < WIN; i++) begin
                if (i < push_count) begin
                    mem[wr_ptr + PTR_W'(i)] <= {lane_row, first_col + COORD_W'(i)};
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(push_count);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill <= fill + FILL_W'(push ? push_count : '0) - FILL_W'(pop);
        end
    end

    assign head.vld  = (fill != '0);
    assign head.addr = mem[rd_ptr];

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (fill + push_count) <= (QUEUE_DEPTH + pop));

    no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> fill != '0);

endmodule

`default_nettype wire

// ==== design/window_picker.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_picker import event_sched_pkg::*; #(
    parameter int HALF_WIN = event_sched_pkg::HALF_WIN,
    localparam int WIN     = 2 * HALF_WIN + 1
) (
    input  lane_head_s [WIN-1:0] heads,
    input  pixel_addr_u          horizon,
    input  logic                 take,
    output logic                 due,
    output pixel_addr_u          due_addr,
    output logic [WIN-1:0]       pop
);

    logic        best_vld;
    pixel_addr_u best;

    ////////////////////////////////////////////////////////////////////////////
    // Minimum over the valid lane heads
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        best_vld = 1'b0;
        best     = '0;
        for (int i = 0; i < WIN; i++) begin
            if (heads[i].vld && (!best_vld || heads[i].addr.linear < best.linear)) begin
                best_vld = 1'b1;
                best     = heads[i].addr;
            end
        end
    end

    // Window must lie fully behind the newest event
    assign due      = best_vld && (best.linear < horizon.linear);
    assign due_addr = best;

    // Every lane holding the chosen window drops it
    always_comb begin
        for (int i = 0; i < WIN; i++) begin
            pop[i] = take && heads[i].vld && (heads[i].addr.linear == best.linear);
        end
    end

    always_comb begin
        take_needs_due: assert final (!take || due)
            else $error("window taken while nothing is due");
    end

endmodule

`default_nettype wire

// ==== design/sched_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_ctrl import event_sched_pkg::*; #(
    parameter int HALF_WIN = event_sched_pkg::HALF_WIN,
    localparam int WIN     = 2 * HALF_WIN + 1,
    localparam int CNT_W   = $clog2(WIN + 1)
) (
    input  logic             clk,
    input  logic             rst_n,

    input  pixel_addr_u      event_addr,
    input  logic             event_valid,
    output logic             event_ready,

    output pixel_addr_u      window_addr,
    output logic             window_valid,
    input  logic             window_ready,

    output logic             push,
    output logic [CNT_W-1:0] push_count,
    output pixel_addr_u      push_base,

    input  logic             due,
    input  pixel_addr_u      due_addr,
    output pixel_addr_u      horizon,
    output logic             take
);

    typedef enum logic [1:0] {
        IDLE,
        PICK,
        OFFER
    } state_e;

    state_e            state;
    pixel_addr_u       last_addr;
    logic [ADDR_W-1:0] addr_diff;
    logic              fresh;

    ////////////////////////////////////////////////////////////////////////////
    // Event side
    ////////////////////////////////////////////////////////////////////////////

    assign event_ready = (state == IDLE);
    assign fresh       = event_addr.linear > last_addr.linear;
    assign addr_diff   = event_addr.linear - last_addr.linear;

    // Columns already queued by the previous event are skipped
    assign push       = event_valid && event_ready && fresh;
    assign push_base  = event_addr;
    assign push_count = (addr_diff >= ADDR_W'(WIN)) ? CNT_W'(WIN) : addr_diff[CNT_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Window side
    ////////////////////////////////////////////////////////////////////////////

    assign window_valid = (state == OFFER);
    assign window_addr  = due_addr;  // Lanes frozen while offering
    assign take         = window_valid && window_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            last_addr <= '0;
            horizon   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (push) begin
                        last_addr      <= event_addr;
                        horizon.linear <= event_addr.linear
                                          - ADDR_W'(HALF_WIN * ROW_STRIDE + HALF_WIN);
                        state          <= PICK;
                    end
                end
                PICK: begin
                    state <= due ? OFFER : IDLE;
                end
                OFFER: begin
                    if (window_ready) begin
                        state <= PICK;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Offer must hold across the picker and the lanes until taken
    offer_stable: assert property (@(posedge clk) disable iff (!rst_n)
        window_valid && !window_ready |=> $stable(window_addr));

endmodule

`default_nettype wire

// ==== design/event_sched_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module event_sched_top import event_sched_pkg::*; #(
    parameter int HALF_WIN    = event_sched_pkg::HALF_WIN,
    parameter int QUEUE_DEPTH = event_sched_pkg::QUEUE_DEPTH,
    localparam int WIN        = 2 * HALF_WIN + 1,
    localparam int CNT_W      = $clog2(WIN + 1)
) (
    input  logic        clk,
    input  logic        rst_n,

    input  pixel_addr_u event_addr,
    input  logic        event_valid,
    output logic        event_ready,

    output pixel_addr_u window_addr,
    output logic        window_valid,
    input  logic        window_ready
);

    logic                 push;
    logic [CNT_W-1:0]     push_count;
    pixel_addr_u          push_base;
    logic                 due;
    pixel_addr_u          due_addr;
    pixel_addr_u          horizon;
    logic                 take;
    lane_head_s [WIN-1:0] heads;
    logic [WIN-1:0]       pop;

    sched_ctrl #(
        .HALF_WIN(HALF_WIN)
    ) sched_ctrl_inst (
        .clk(clk),
        .rst_n(rst_n),
        .event_addr(event_addr),
        .event_valid(event_valid),
        .event_ready(event_ready),
        .window_addr(window_addr),
        .window_valid(window_valid),
        .window_ready(window_ready),
        .push(push),
        .push_count(push_count),
        .push_base(push_base),
        .due(due),
        .due_addr(due_addr),
        .horizon(horizon),
        .take(take)
    );

    window_picker #(
        .HALF_WIN(HALF_WIN)
    ) window_picker_inst (
        .heads(heads),
        .horizon(horizon),
        .take(take),
        .due(due),
        .due_addr(due_addr),
        .pop(pop)
    );

    // Lane g holds window row g counted from the top
    for (genvar g = 0; g < WIN; g++) begin : g_lane
        todo_lane #(
            .HALF_WIN(HALF_WIN),
            .QUEUE_DEPTH(QUEUE_DEPTH),
            .LANE(g)
        ) todo_lane_inst (
            .clk(clk),
            .rst_n(rst_n),
            .push(push),
            .push_count(push_count),
            .push_base(push_base),
            .pop(pop[g]),
            .head(heads[g])
        );
    end

endmodule

`default_nettype wire

// ==== sim/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_addr(input pixel_addr_u actual, input pixel_addr_u wanted,
                          input string what);
    if (actual !== wanted) begin
        $display("ERROR at %0t ns: %s, got row %0d col %0d, expected row %0d col %0d",
                 $time, what, actual.rc.row, actual.rc.col, wanted.rc.row, wanted.rc.col);
        $display("sim failed");
        $fatal(1, "address mismatch");
    end
endtask

task automatic check_bit(input logic actual, input logic wanted, input string what);
    if (actual !== wanted) begin
        $display("ERROR at %0t ns: %s, got %b, expected %b", $time, what, actual, wanted);
        $display("sim failed");
        $fatal(1, "bit mismatch");
    end
endtask

// Called just after a falling edge
task automatic send_event(input pixel_addr_u addr);
    event_addr  = addr;
    event_valid = 1'b1;
    while (!event_ready) begin
        @(negedge clk);
    end
    @(negedge clk);  // Transfer on the rising edge in between
    event_valid = 1'b0;
endtask

// Takes windows until the DUT is ready for the next event
task automatic collect_windows(input bit back_pressure, output int seen);
    pixel_addr_u held;
    logic        waiting;
    seen    = 0;
    waiting = 1'b0;
    held    = '0;
    while (!event_ready) begin
        if (back_pressure) begin
            lfsr_state   = lfsr_next(lfsr_state);
            window_ready = lfsr_state[0];
        end else begin
            window_ready = 1'b1;
        end
        if (waiting) begin
            check_bit(window_valid, 1'b1, "window_valid dropped before transfer");
            check_addr(window_addr, held, "window changed before transfer");
        end else if (window_valid) begin
            check_bit(expected.size() != 0, 1'b1, "window with none expected");
            check_addr(window_addr, expected[0], "window address");
            check_bit(window_addr.linear > last_window.linear, 1'b1, "window order");
        end
        if (window_valid) begin
            held    = window_addr;
            waiting = !window_ready;
            if (window_ready) begin
                void'(expected.pop_front());
                last_window = window_addr;
                seen++;
            end
        end
        @(negedge clk);
    end
    window_ready = 1'b1;
    check_bit(window_valid, 1'b0, "window offered while idle");
    check_bit(expected.size() == 0, 1'b1, "burst ended with windows missing");
endtask

`endif

// ==== sim/tb_event_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_event_sched import event_sched_pkg::*; ();

    localparam int WIN_RADIUS  = 2;  // DUT default
    localparam int WIN_SIZE    = 2 * WIN_RADIUS + 1;
    localparam int COORD_BITS  = ADDR_W / 2;  // Row or column
    // Summed over all tests
    localparam int NUM_EVENTS  = 11;
    localparam int NUM_WINDOWS = 165;
    localparam int CYCLE_LIMIT = 4 * NUM_WINDOWS + 10 * NUM_EVENTS + 200;

    logic        clk;
    logic        rst_n;
    pixel_addr_u event_addr;
    logic        event_valid;
    logic        event_ready;
    pixel_addr_u window_addr;
    logic        window_valid;
    logic        window_ready;

    pixel_addr_u model_last;
    pixel_addr_u pending [$];   // Sorted without duplicates
    pixel_addr_u expected [$];  // Windows still owed by the DUT
    pixel_addr_u last_window;
    logic [31:0] lfsr_state;
    int          cycles;

    event_sched_top event_sched_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .event_addr(event_addr),
        .event_valid(event_valid),
        .event_ready(event_ready),
        .window_addr(window_addr),
        .window_valid(window_valid),
        .window_ready(window_ready)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("DUT stopped responding within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    `include "tb_checks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // Taps 32 22 2 1
    endfunction

    function automatic pixel_addr_u pixel_at(input int row, input int col);
        pixel_addr_u a;
        a.rc.row = COORD_BITS'(row);
        a.rc.col = COORD_BITS'(col);
        return a;
    endfunction

    function automatic void add_pending(input pixel_addr_u a);
        int pos;
        pos = 0;
        while (pos < pending.size() && pending[pos].linear < a.linear) begin
            pos++;
        end
        if (pos < pending.size() && pending[pos].linear == a.linear) begin
            return;  // Already queued by an earlier event
        end
        pending.insert(pos, a);
    endfunction

    function automatic void model_event(input pixel_addr_u ev);
        int          count;
        pixel_addr_u win;
        pixel_addr_u horizon;
        if (ev.linear <= model_last.linear) begin
            return;  // Stale
        end
        count = int'(ev.linear - model_last.linear);
        if (count > WIN_SIZE) begin
            count = WIN_SIZE;
        end
        model_last = ev;
        for (int lane = 0; lane < WIN_SIZE; lane++) begin
            for (int k = WIN_SIZE - count; k < WIN_SIZE; k++) begin
                win.rc.row = ev.rc.row - COORD_BITS'(WIN_RADIUS) + COORD_BITS'(lane);
                win.rc.col = ev.rc.col - COORD_BITS'(WIN_RADIUS) + COORD_BITS'(k);
                add_pending(win);
            end
        end
        horizon.rc.row = ev.rc.row - COORD_BITS'(WIN_RADIUS);
        horizon.rc.col = ev.rc.col - COORD_BITS'(WIN_RADIUS);
        while (pending.size() != 0 && pending[0].linear < horizon.linear) begin
            expected.push_back(pending.pop_front());
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_event(input int row, input int col, input bit back_pressure,
                             output int seen);
        pixel_addr_u ev;
        ev = pixel_at(row, col);
        model_event(ev);
        send_event(ev);
        collect_windows(back_pressure, seen);
    endtask

    task automatic test_reset_state();
        check_bit(event_ready, 1'b1, "event_ready after reset");
        check_bit(window_valid, 1'b0, "window_valid after reset");
    endtask

    task automatic test_first_event();
        int seen;
        run_event(40, 40, 1'b0, seen);
        check_bit(seen == 0, 1'b1, "first event released windows");
    endtask

    task automatic test_drain();
        int seen;
        run_event(60, 60, 1'b0, seen);
        check_bit(seen == 25, 1'b1, "drain count");
    endtask

    task automatic test_overlap();
        int seen;
        run_event(80, 100, 1'b0, seen);
        run_event(80, 101, 1'b0, seen);
        run_event(80, 103, 1'b0, seen);
        run_event(100, 100, 1'b0, seen);  // Distant event drains the row
    endtask

    task automatic test_back_pressure();
        int seen;
        run_event(120, 50, 1'b1, seen);
        run_event(130, 80, 1'b1, seen);
    endtask

    task automatic test_stale();
        int seen;
        run_event(130, 80, 1'b0, seen);
        check_bit(seen == 0, 1'b1, "repeated event released windows");
        run_event(110, 20, 1'b0, seen);
        check_bit(seen == 0, 1'b1, "older event released windows");
        run_event(150, 150, 1'b0, seen);
        check_bit(seen == 25, 1'b1, "count after stale events");
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        event_addr   = '0;
        event_valid  = 1'b0;
        window_ready = 1'b1;
        model_last   = '0;
        last_window  = '0;
        lfsr_state   = 32'h83ea_331c;
        cycles       = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_first_event();
        test_drain();
        test_overlap();
        test_back_pressure();
        test_stale();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+sim
design/event_sched_pkg.sv
design/todo_lane.sv
design/window_picker.sv
design/sched_ctrl.sv
design/event_sched_top.sv
sim/tb_event_sched.sv

// ==== Bender.yml ====
package:
  name: event_sched

sources:
  - design/event_sched_pkg.sv
  - design/todo_lane.sv
  - design/window_picker.sv
  - design/sched_ctrl.sv
  - design/event_sched_top.sv

  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_event_sched.sv
